// File: ccu_iteration_planner.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_iteration_planner #(
  parameter int RSLT_CHANNELS = 4
) (
  input  wire                               fsm_clk,
  input  wire                               fsm_rst,
  input  wire                               plan_load,
  input  wire                               plan_step,
  input  wire                               rslt_tlast,
  input  wire [ccu_pkg::CTRL_DATA_W-1:0]    rslt_size,
  output logic [RSLT_CHANNELS-1:0]          use_channels_next,
  output logic                              last_iteration,
  output logic [ccu_pkg::CTRL_DATA_W-1:0]   results_exported,
  output logic [ccu_pkg::CTRL_DATA_W-1:0]   iteration_count
);
  import ccu_pkg::*;

  localparam logic [CTRL_DATA_W-1:0] CHANNELS = CTRL_DATA_W'(RSLT_CHANNELS);

  logic [CTRL_DATA_W-1:0] results_left;
  logic [CTRL_DATA_W-1:0] iter_size;
  // Size of the iteration in flight, credited on its tlast
  logic [CTRL_DATA_W-1:0] pending_size;

  assign iter_size      = (results_left > CHANNELS) ? CHANNELS : results_left;
  assign last_iteration = (results_left == '0);

  always_comb begin
    for (int ch = 0; ch < RSLT_CHANNELS; ch++) begin
      use_channels_next[ch] = (CTRL_DATA_W'(ch) < iter_size);
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      results_left     <= '0;
      pending_size     <= '0;
      results_exported <= '0;
      iteration_count  <= '0;
    end else if (plan_load) begin
      results_left     <= rslt_size;
      pending_size     <= '0;
      results_exported <= '0;
      iteration_count  <= '0;
    end else begin
      if (rslt_tlast) begin
        iteration_count  <= iteration_count + CTRL_DATA_W'(1);
        results_exported <= results_exported + pending_size;
        pending_size     <= '0;
      end
      // A new issue in the tlast cycle replaces the credited size
      if (plan_step) begin
        results_left <= results_left - iter_size;
        pending_size <= iter_size;
      end
    end
  end

endmodule

`default_nettype wire

// File: ccu_patterns.txt
# op field data expect, all numbers hex; W write field=addr, R read field=addr and compare
# T rslt_tlast pulse, P peripheral errors=data, Q wait: field 0 idle cycles, 1-4 pulse, 5 flags
# Outputs after reset
Q 5 0 00
# Sizes, loaded flags and readback
W 00 100 0
W 04 40 0
W 08 20 0
W 0C A 0
W 10 8 0
W 14 F 0
R 00 0 100
R 04 0 40
R 08 0 20
R 0C 0 A
R 10 0 8
R 14 0 F
W 20 FF 0
R 20 0 11
R 1C 0 0
R 30 0 0
# Start with a zero packet size, then abort
W 10 0 0
R 20 0 1
W 18 1 0
Q 0 2 0
Q 5 0 0A
R 20 0 C
R 18 0 0
W 1C 1 0
Q 0 3 0
Q 5 0 00
R 20 0 1
# Ten results over four channels
W 10 8 0
R 20 0 11
W 18 1 0
Q 1 0 0
Q 2 0 F
T 0 0 0
Q 2 0 F
T 0 0 0
Q 2 0 3
T 0 0 0
Q 3 0 0
Q 5 0 02
R 24 0 A
R 28 0 3
R 20 0 18
R 18 0 2
Q 0 3 0
Q 5 0 02
# Done bit cleared by software
W 18 0 0
Q 0 1 0
Q 5 0 00
R 20 0 11
# Peripheral error during an operation, then error command
W 18 1 0
Q 1 0 0
Q 2 0 F
P 0 1 0
Q 4 0 0
Q 5 0 0A
R 20 0 1C
P 0 0 0
Q 0 3 0
W 1C 2 0
Q 0 2 0
Q 5 0 00
R 20 0 11
R 18 0 2

// File: ccu_pkg.sv
`default_nettype none

package ccu_pkg;

  localparam int CTRL_DATA_W = 32;
  localparam int CTRL_ADDR_W = 8;

  // Register map, byte offsets on the control bus
  typedef enum logic [CTRL_ADDR_W-1:0] {
    ADDR_DATA_SIZE = 8'h00,
    ADDR_GRID_SIZE = 8'h04,
    ADDR_SCLE_SIZE = 8'h08,
    ADDR_RSLT_SIZE = 8'h0C,
    ADDR_PCKT_SIZE = 8'h10,
    ADDR_LOADED    = 8'h14,
    ADDR_CONTROL   = 8'h18,
    ADDR_COMMAND   = 8'h1C,
    ADDR_STATUS    = 8'h20,
    ADDR_PROGRESS  = 8'h24,
    ADDR_ITERATION = 8'h28
  } reg_addr_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_OPERATE,
    ST_DONE,
    ST_ERROR,
    ST_ABORT
  } ccu_state_e;

  typedef struct packed {
    logic                   wr_en;
    logic                   rd_en;
    logic [CTRL_ADDR_W-1:0] addr;
    logic [CTRL_DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                   rd_valid;
    logic [CTRL_DATA_W-1:0] rdata;
  } reg_rsp_t;

  // Operand sizes as written by software
  typedef struct packed {
    logic [CTRL_DATA_W-1:0] data_size;
    logic [CTRL_DATA_W-1:0] grid_size;
    logic [CTRL_DATA_W-1:0] scle_size;
    logic [CTRL_DATA_W-1:0] rslt_size;
    logic [CTRL_DATA_W-1:0] pckt_size;
  } op_config_t;

  typedef struct packed {
    logic idle;
    logic busy;
    logic error;
    logic locked;
  } ccu_status_t;

endpackage

`default_nettype wire

// File: ccu_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_register_file #(
  parameter int DATA_ADDR  = 16,
  parameter int GRID_ADDR  = 16,
  parameter int SCALE_ADDR = 16
) (
  input  wire                              fsm_clk,
  input  wire                              fsm_rst,
  input  wire ccu_pkg::reg_req_t           reg_req,
  output ccu_pkg::reg_rsp_t                reg_rsp,
  input  wire                              start_clr,
  input  wire                              done_set,
  input  wire ccu_pkg::ccu_status_t        status,
  input  wire [ccu_pkg::CTRL_DATA_W-1:0]   results_exported,
  input  wire [ccu_pkg::CTRL_DATA_W-1:0]   iteration_count,
  output ccu_pkg::op_config_t              cfg,
  output logic                             start_req,
  output logic                             done_flag,
  output logic                             op_valid,
  output logic                             abort_cmd,
  output logic                             error_cmd
);
  import ccu_pkg::*;

  // Largest legal size for each addressed memory
  localparam logic [CTRL_DATA_W:0] MAX_DATA_SIZE = (CTRL_DATA_W + 1)'(1) << DATA_ADDR;
  localparam logic [CTRL_DATA_W:0] MAX_GRID_SIZE = (CTRL_DATA_W + 1)'(1) << GRID_ADDR;
  localparam logic [CTRL_DATA_W:0] MAX_SCLE_SIZE = (CTRL_DATA_W + 1)'(1) << SCALE_ADDR;

  logic [3:0]             loaded;
  logic                   rd_valid_q;
  logic [CTRL_DATA_W-1:0] rdata_q;
  logic [CTRL_DATA_W-1:0] rdata_next;

  assign op_valid = (&loaded) &&
                    (cfg.data_size != '0) && (cfg.grid_size != '0) &&
                    (cfg.scle_size != '0) && (cfg.rslt_size != '0) &&
                    (cfg.pckt_size != '0) &&
                    ({1'b0, cfg.data_size} <= MAX_DATA_SIZE) &&
                    ({1'b0, cfg.grid_size} <= MAX_GRID_SIZE) &&
                    ({1'b0, cfg.scle_size} <= MAX_SCLE_SIZE);

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      cfg       <= '0;
      loaded    <= '0;
      start_req <= 1'b0;
      done_flag <= 1'b0;
      abort_cmd <= 1'b0;
      error_cmd <= 1'b0;
    end else begin
      // Commands only live for one cycle
      abort_cmd <= 1'b0;
      error_cmd <= 1'b0;
      if (reg_req.wr_en) begin
        case (reg_req.addr)
          ADDR_DATA_SIZE: cfg.data_size <= reg_req.wdata;
          ADDR_GRID_SIZE: cfg.grid_size <= reg_req.wdata;
          ADDR_SCLE_SIZE: cfg.scle_size <= reg_req.wdata;
          ADDR_RSLT_SIZE: cfg.rslt_size <= reg_req.wdata;
          ADDR_PCKT_SIZE: cfg.pckt_size <= reg_req.wdata;
          ADDR_LOADED:    loaded        <= reg_req.wdata[3:0];
          ADDR_CONTROL: begin
            start_req <= reg_req.wdata[0];
            done_flag <= reg_req.wdata[1];
          end
          ADDR_COMMAND: begin
            abort_cmd <= reg_req.wdata[0];
            error_cmd <= reg_req.wdata[1];
          end
          default: begin
          end
        endcase
      end
      // Hardware updates win over a software write in the same cycle
      if (start_clr) begin
        start_req <= 1'b0;
      end
      if (done_set) begin
        done_flag <= 1'b1;
      end
    end
  end

  always_comb begin
    rdata_next = '0;
    case (reg_req.addr)
      ADDR_DATA_SIZE: rdata_next = cfg.data_size;
      ADDR_GRID_SIZE: rdata_next = cfg.grid_size;
      ADDR_SCLE_SIZE: rdata_next = cfg.scle_size;
      ADDR_RSLT_SIZE: rdata_next = cfg.rslt_size;
      ADDR_PCKT_SIZE: rdata_next = cfg.pckt_size;
      ADDR_LOADED:    rdata_next = {28'd0, loaded};
      ADDR_CONTROL:   rdata_next = {30'd0, done_flag, start_req};
      ADDR_STATUS: begin
        rdata_next = {27'd0, op_valid, status.locked, status.error,
                      status.busy, status.idle};
      end
      ADDR_PROGRESS:  rdata_next = results_exported;
      ADDR_ITERATION: rdata_next = iteration_count;
      default:        rdata_next = '0;
    endcase
  end

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= reg_req.rd_en;
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (reg_req.rd_en) begin
      rdata_q <= rdata_next;
    end
  end

  assign reg_rsp.rd_valid = rd_valid_q;
  assign reg_rsp.rdata    = rdata_q;

endmodule

`default_nettype wire

// File: ccu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_sequencer #(
  parameter int RSLT_CHANNELS   = 4,
  parameter int DATA_ADDR       = 16,
  parameter int GRID_ADDR       = 16,
  parameter int SCALE_ADDR      = 16,
  parameter int NUM_PERIPHERALS = 2
) (
  input  wire                              fsm_clk,
  input  wire                              fsm_rst,
  input  wire                              start_req,
  input  wire                              op_valid,
  input  wire                              done_flag,
  input  wire                              abort_cmd,
  input  wire                              error_cmd,
  input  wire ccu_pkg::op_config_t         cfg,
  input  wire                              last_iteration,
  input  wire [RSLT_CHANNELS-1:0]          use_channels_next,
  input  wire                              rslt_tlast,
  input  wire [NUM_PERIPHERALS-1:0]        peripheral_operation_error,
  output logic                             start_clr,
  output logic                             done_set,
  output logic                             plan_load,
  output logic                             plan_step,
  output ccu_pkg::ccu_status_t             status,
  output logic                             operation_start,
  output logic [DATA_ADDR:0]               data_size,
  output logic [GRID_ADDR:0]               grid_size,
  output logic [SCALE_ADDR:0]              scle_size,
  output logic [ccu_pkg::CTRL_DATA_W-1:0]  pckt_size,
  output logic                             iteration_start,
  output logic [RSLT_CHANNELS-1:0]         use_channels,
  output logic                             operation_busy,
  output logic                             operation_complete,
  output logic                             operation_error,
  output logic                             internal_operation_error,
  output logic                             locked,
  output logic                             pl2ps_intr
);
  import ccu_pkg::*;

  ccu_state_e                 state;
  ccu_state_e                 state_next;
  logic [NUM_PERIPHERALS-1:0] perr_meta;
  logic [NUM_PERIPHERALS-1:0] perr_sync;
  logic                       periph_error;
  logic                       enter_done;
  logic                       enter_error;

  // Peripheral errors come from other clock domains
  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      perr_meta <= '0;
      perr_sync <= '0;
    end else begin
      perr_meta <= peripheral_operation_error;
      perr_sync <= perr_meta;
    end
  end

  assign periph_error = |perr_sync;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (start_req) begin
          state_next = op_valid ? ST_START : ST_ERROR;
        end
      end
      ST_START:   state_next = ST_OPERATE;
      ST_OPERATE: begin
        if (rslt_tlast && last_iteration) begin
          state_next = ST_DONE;
        end
      end
      // Stay locked until software acknowledges
      ST_DONE: begin
        if (!done_flag) begin
          state_next = ST_IDLE;
        end
      end
      ST_ERROR:   state_next = ST_ERROR;
      ST_ABORT:   state_next = ST_IDLE;
      default:    state_next = ST_IDLE;
    endcase
    if (periph_error) begin
      state_next = ST_ERROR;
    end
    // Software commands override everything else
    if (abort_cmd || error_cmd) begin
      state_next = ST_ABORT;
    end
  end

  assign start_clr   = (state == ST_IDLE) && start_req;
  assign plan_load   = (state == ST_IDLE) && (state_next == ST_START);
  assign plan_step   = ((state == ST_START) && (state_next == ST_OPERATE)) ||
                       ((state == ST_OPERATE) && (state_next == ST_OPERATE) &&
                        rslt_tlast && !last_iteration);
  assign enter_done  = (state == ST_OPERATE) && (state_next == ST_DONE);
  assign enter_error = (state_next == ST_ERROR) && (state != ST_ERROR);
  assign done_set    = enter_done || error_cmd;

  assign status.idle   = (state == ST_IDLE);
  assign status.busy   = (state == ST_START) || (state == ST_OPERATE);
  assign status.error  = (state == ST_ERROR);
  assign status.locked = locked;

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      state                    <= ST_IDLE;
      operation_start          <= 1'b0;
      iteration_start          <= 1'b0;
      operation_busy           <= 1'b0;
      operation_complete       <= 1'b0;
      operation_error          <= 1'b0;
      internal_operation_error <= 1'b0;
      locked                   <= 1'b0;
      pl2ps_intr               <= 1'b0;
    end else begin
      state              <= state_next;
      operation_start    <= plan_load;
      iteration_start    <= plan_step;
      operation_busy     <= (state_next == ST_START) || (state_next == ST_OPERATE);
      operation_complete <= enter_done;
      // An abort only flags an error when software asked for one
      operation_error    <= (state_next == ST_ERROR) ||
                            ((state_next == ST_ABORT) && error_cmd);
      internal_operation_error <= enter_error && periph_error;
      locked             <= (state_next == ST_DONE) || (state_next == ST_ERROR);
      pl2ps_intr         <= plan_load || ((state == ST_OPERATE) && rslt_tlast) ||
                            enter_done || enter_error;
    end
  end

  // Sizes and mask are only meaningful alongside their strobes
  always_ff @(posedge fsm_clk) begin
    if (plan_load) begin
      data_size <= cfg.data_size[DATA_ADDR:0];
      grid_size <= cfg.grid_size[GRID_ADDR:0];
      scle_size <= cfg.scle_size[SCALE_ADDR:0];
      pckt_size <= cfg.pckt_size;
    end
    if (plan_step) begin
      use_channels <= use_channels_next;
    end
  end

endmodule

`default_nettype wire

// File: ccu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ccu_top #(
  parameter int RSLT_CHANNELS   = 4,
  parameter int DATA_ADDR       = 16,
  parameter int GRID_ADDR       = 16,
  parameter int SCALE_ADDR      = 16,
  parameter int NUM_PERIPHERALS = 2
) (
  input  wire                              fsm_clk,
  input  wire                              fsm_rst,
  input  wire ccu_pkg::reg_req_t           reg_req,
  output ccu_pkg::reg_rsp_t                reg_rsp,
  input  wire [NUM_PERIPHERALS-1:0]        peripheral_operation_error,
  input  wire                              rslt_tlast,
  output wire                              operation_start,
  output wire [DATA_ADDR:0]                data_size,
  output wire [GRID_ADDR:0]                grid_size,
  output wire [SCALE_ADDR:0]               scle_size,
  output wire [ccu_pkg::CTRL_DATA_W-1:0]   pckt_size,
  output wire                              iteration_start,
  output wire [RSLT_CHANNELS-1:0]          use_channels,
  output wire                              operation_busy,
  output wire                              operation_complete,
  output wire                              operation_error,
  output wire                              internal_operation_error,
  output wire                              locked,
  output wire                              pl2ps_intr
);
  import ccu_pkg::*;

  op_config_t             cfg;
  ccu_status_t            status;
  logic                   start_req;
  logic                   done_flag;
  logic                   op_valid;
  logic                   abort_cmd;
  logic                   error_cmd;
  logic                   start_clr;
  logic                   done_set;
  logic                   plan_load;
  logic                   plan_step;
  logic                   last_iteration;
  logic [RSLT_CHANNELS-1:0] use_channels_next;
  logic [CTRL_DATA_W-1:0] results_exported;
  logic [CTRL_DATA_W-1:0] iteration_count;

  ccu_register_file #(
    .DATA_ADDR  (DATA_ADDR),
    .GRID_ADDR  (GRID_ADDR),
    .SCALE_ADDR (SCALE_ADDR)
  ) ccu_register_file_inst (
    .fsm_clk          (fsm_clk),
    .fsm_rst          (fsm_rst),
    .reg_req          (reg_req),
    .reg_rsp          (reg_rsp),
    .start_clr        (start_clr),
    .done_set         (done_set),
    .status           (status),
    .results_exported (results_exported),
    .iteration_count  (iteration_count),
    .cfg              (cfg),
    .start_req        (start_req),
    .done_flag        (done_flag),
    .op_valid         (op_valid),
    .abort_cmd        (abort_cmd),
    .error_cmd        (error_cmd)
  );

  ccu_iteration_planner #(
    .RSLT_CHANNELS (RSLT_CHANNELS)
  ) ccu_iteration_planner_inst (
    .fsm_clk           (fsm_clk),
    .fsm_rst           (fsm_rst),
    .plan_load         (plan_load),
    .plan_step         (plan_step),
    .rslt_tlast        (rslt_tlast),
    .rslt_size         (cfg.rslt_size),
    .use_channels_next (use_channels_next),
    .last_iteration    (last_iteration),
    .results_exported  (results_exported),
    .iteration_count   (iteration_count)
  );

  ccu_sequencer #(
    .RSLT_CHANNELS   (RSLT_CHANNELS),
    .DATA_ADDR       (DATA_ADDR),
    .GRID_ADDR       (GRID_ADDR),
    .SCALE_ADDR      (SCALE_ADDR),
    .NUM_PERIPHERALS (NUM_PERIPHERALS)
  ) ccu_sequencer_inst (
    .fsm_clk                    (fsm_clk),
    .fsm_rst                    (fsm_rst),
    .start_req                  (start_req),
    .op_valid                   (op_valid),
    .done_flag                  (done_flag),
    .abort_cmd                  (abort_cmd),
    .error_cmd                  (error_cmd),
    .cfg                        (cfg),
    .last_iteration             (last_iteration),
    .use_channels_next          (use_channels_next),
    .rslt_tlast                 (rslt_tlast),
    .peripheral_operation_error (peripheral_operation_error),
    .start_clr                  (start_clr),
    .done_set                   (done_set),
    .plan_load                  (plan_load),
    .plan_step                  (plan_step),
    .status                     (status),
    .operation_start            (operation_start),
    .data_size                  (data_size),
    .grid_size                  (grid_size),
    .scle_size                  (scle_size),
    .pckt_size                  (pckt_size),
    .iteration_start            (iteration_start),
    .use_channels               (use_channels),
    .operation_busy             (operation_busy),
    .operation_complete         (operation_complete),
    .operation_error            (operation_error),
    .internal_operation_error   (internal_operation_error),
    .locked                     (locked),
    .pl2ps_intr                 (pl2ps_intr)
  );

endmodule

`default_nettype wire

// File: tb_ccu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ccu;
  import ccu_pkg::*;

  localparam int RSLT_CHANNELS   = 4;
  localparam int DATA_ADDR       = 16;
  localparam int GRID_ADDR       = 16;
  localparam int SCALE_ADDR      = 16;
  localparam int NUM_PERIPHERALS = 2;
  localparam int CLK_PERIOD      = 100;
  localparam int PULSE_WAIT      = 32;
  localparam logic [31:0] DATA_MASK = (32'd1 << (DATA_ADDR + 1)) - 32'd1;
  localparam logic [31:0] GRID_MASK = (32'd1 << (GRID_ADDR + 1)) - 32'd1;
  localparam logic [31:0] SCLE_MASK = (32'd1 << (SCALE_ADDR + 1)) - 32'd1;

  logic                       fsm_clk;
  logic                       fsm_rst;
  reg_req_t                   reg_req;
  reg_rsp_t                   reg_rsp;
  logic [NUM_PERIPHERALS-1:0] peripheral_operation_error;
  logic                       rslt_tlast;
  logic                       operation_start;
  logic [DATA_ADDR:0]         data_size;
  logic [GRID_ADDR:0]         grid_size;
  logic [SCALE_ADDR:0]        scle_size;
  logic [CTRL_DATA_W-1:0]     pckt_size;
  logic                       iteration_start;
  logic [RSLT_CHANNELS-1:0]   use_channels;
  logic                       operation_busy;
  logic                       operation_complete;
  logic                       operation_error;
  logic                       internal_operation_error;
  logic                       locked;
  logic                       pl2ps_intr;

  // One entry per pattern line
  byte         step_op[$];
  logic [31:0] step_field[$];
  logic [31:0] step_data[$];
  logic [31:0] step_expect[$];

  // Last written sizes, expected on operation_start
  logic [31:0] shadow_data;
  logic [31:0] shadow_grid;
  logic [31:0] shadow_scle;
  logic [31:0] shadow_pckt;

  int seen_pulses[1:4];
  int expected_pulses[1:4];
  int cycle_count = 0;
  int cycle_limit = 0;

  // Inputs as the DUT saw them, for the interrupt and command rules
  logic tlast_at_edge = 1'b0;
  logic cmd_at_edge   = 1'b0;
  logic cmd_error_q   = 1'b0;
  logic cmd_in_abort  = 1'b0;
  logic err_in_abort  = 1'b0;
  logic in_error_q    = 1'b0;
  logic error_entry;

  ccu_top #(
    .RSLT_CHANNELS   (RSLT_CHANNELS),
    .DATA_ADDR       (DATA_ADDR),
    .GRID_ADDR       (GRID_ADDR),
    .SCALE_ADDR      (SCALE_ADDR),
    .NUM_PERIPHERALS (NUM_PERIPHERALS)
  ) ccu_top_inst (
    .fsm_clk                    (fsm_clk),
    .fsm_rst                    (fsm_rst),
    .reg_req                    (reg_req),
    .reg_rsp                    (reg_rsp),
    .peripheral_operation_error (peripheral_operation_error),
    .rslt_tlast                 (rslt_tlast),
    .operation_start            (operation_start),
    .data_size                  (data_size),
    .grid_size                  (grid_size),
    .scle_size                  (scle_size),
    .pckt_size                  (pckt_size),
    .iteration_start            (iteration_start),
    .use_channels               (use_channels),
    .operation_busy             (operation_busy),
    .operation_complete         (operation_complete),
    .operation_error            (operation_error),
    .internal_operation_error   (internal_operation_error),
    .locked                     (locked),
    .pl2ps_intr                 (pl2ps_intr)
  );

  initial begin
    fsm_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) fsm_clk = ~fsm_clk;
    end
  end

  task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s expected %h got %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  always @(posedge fsm_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the pattern run did not end within %0d clock cycles", cycle_limit);
      stop_on_failure();
    end
  end

  function automatic logic event_level(input logic [31:0] field);
    case (field)
      1:       return operation_start;
      2:       return iteration_start;
      3:       return operation_complete;
      default: return internal_operation_error;
    endcase
  endfunction

  function automatic string pulse_name(input logic [31:0] field);
    case (field)
      1:       return "operation_start";
      2:       return "iteration_start";
      3:       return "operation_complete";
      default: return "internal_operation_error";
    endcase
  endfunction

  // Every one-cycle pulse seen must be one that a pattern waited for
  always @(negedge fsm_clk) begin
    if (!fsm_rst) begin
      for (int k = 1; k <= 4; k++) begin
        if (event_level(k)) begin
          seen_pulses[k]++;
        end
      end
    end
  end

  // A command write reaches the abort state two edges later
  always @(posedge fsm_clk) begin
    tlast_at_edge <= rslt_tlast;
    cmd_at_edge   <= reg_req.wr_en && (reg_req.addr == ADDR_COMMAND) &&
                     (reg_req.wdata[1:0] != 2'b00);
    cmd_error_q   <= reg_req.wdata[1];
    cmd_in_abort  <= cmd_at_edge;
    err_in_abort  <= cmd_error_q;
  end

  // Interrupt on start, on each tlast, on completion and on error entry
  always @(negedge fsm_clk) begin
    if (!fsm_rst) begin
      error_entry = operation_error && locked && !in_error_q;
      check_value("pl2ps_intr",
                  operation_start || tlast_at_edge || operation_complete || error_entry,
                  pl2ps_intr);
      in_error_q = operation_error && locked;
      // The abort cycle flags an error only for an error command
      if (cmd_in_abort) begin
        check_value("operation_error", err_in_abort, operation_error);
        check_value("locked", 32'd0, locked);
      end
    end
  end

  task automatic next_cycle();
    @(negedge fsm_clk);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    reg_req.wr_en = 1'b1;
    reg_req.addr  = addr[CTRL_ADDR_W-1:0];
    reg_req.wdata = data;
    case (addr[CTRL_ADDR_W-1:0])
      ADDR_DATA_SIZE: shadow_data = data;
      ADDR_GRID_SIZE: shadow_grid = data;
      ADDR_SCLE_SIZE: shadow_scle = data;
      ADDR_PCKT_SIZE: shadow_pckt = data;
      default: begin
      end
    endcase
    next_cycle();
    reg_req.wr_en = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected);
    reg_req.rd_en = 1'b1;
    reg_req.addr  = addr[CTRL_ADDR_W-1:0];
    next_cycle();
    reg_req.rd_en = 1'b0;
    // The response follows the request by exactly one cycle
    check_value("rd_valid", 32'd1, reg_rsp.rd_valid);
    check_value($sformatf("rdata[%h]", addr[CTRL_ADDR_W-1:0]), expected, reg_rsp.rdata);
  endtask

  task automatic pulse_tlast();
    rslt_tlast = 1'b1;
    next_cycle();
    rslt_tlast = 1'b0;
  endtask

  task automatic wait_for_pulse(input logic [31:0] field);
    int waited;
    waited = 0;
    while (!event_level(field)) begin
      if (waited == PULSE_WAIT) begin
        $display("%s did not pulse within %0d cycles", pulse_name(field), PULSE_WAIT);
        stop_on_failure();
      end
      next_cycle();
      waited++;
    end
    expected_pulses[field]++;
  endtask

  task automatic run_wait(input logic [31:0] field, input logic [31:0] data,
                          input logic [31:0] expected);
    case (field)
      0: repeat (data) next_cycle();
      1, 2, 3, 4: begin
        wait_for_pulse(field);
        // Busy covers the start cycle and the iterations, not completion or error
        check_value("operation_busy", (field == 1) || (field == 2), operation_busy);
        if (field == 1) begin
          check_value("data_size", shadow_data & DATA_MASK, data_size);
          check_value("grid_size", shadow_grid & GRID_MASK, grid_size);
          check_value("scle_size", shadow_scle & SCLE_MASK, scle_size);
          check_value("pckt_size", shadow_pckt, pckt_size);
        end
        if (field == 2) begin
          check_value("use_channels", expected, use_channels);
        end
        // Pulses last exactly one cycle
        next_cycle();
        check_value(pulse_name(field), 32'd0, event_level(field));
      end
      5: begin
        check_value("output flags", expected,
                    {operation_start, iteration_start, operation_busy, operation_complete,
                     operation_error, internal_operation_error, locked, pl2ps_intr});
      end
      default: begin
        $display("Unknown wait field %h in the pattern file", field);
        stop_on_failure();
      end
    endcase
  endtask

  task automatic run_step(input byte op, input logic [31:0] field, input logic [31:0] data,
                          input logic [31:0] expected);
    case (op)
      "W": bus_write(field, data);
      "R": bus_read(field, expected);
      "T": pulse_tlast();
      "P": peripheral_operation_error = data[NUM_PERIPHERALS-1:0];
      "Q": run_wait(field, data, expected);
      default: begin
        $display("Unknown op code %c in the pattern file", op);
        stop_on_failure();
      end
    endcase
  endtask

  task automatic load_patterns();
    int          fd;
    int          fields;
    int          got;
    string       line;
    byte         op;
    logic [31:0] field;
    logic [31:0] data;
    logic [31:0] expected;
    fd = $fopen("ccu_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file ccu_patterns.txt");
      stop_on_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      // Skip blank and comment lines
      if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%c %h %h %h", op, field, data, expected);
        if (fields != 4) begin
          $display("Malformed pattern line: %s", line);
          stop_on_failure();
        end
        step_op.push_back(op);
        step_field.push_back(field);
        step_data.push_back(data);
        step_expect.push_back(expected);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int n;
    fsm_rst                    = 1'b1;
    reg_req                    = '0;
    rslt_tlast                 = 1'b0;
    peripheral_operation_error = '0;
    shadow_data                = '0;
    shadow_grid                = '0;
    shadow_scle                = '0;
    shadow_pckt                = '0;
    for (n = 1; n <= 4; n++) begin
      seen_pulses[n]     = 0;
      expected_pulses[n] = 0;
    end
    load_patterns();
    cycle_limit = 20 * step_op.size() + 100;
    repeat (4) next_cycle();
    fsm_rst = 1'b0;
    for (n = 0; n < step_op.size(); n++) begin
      run_step(step_op[n], step_field[n], step_data[n], step_expect[n]);
    end
    for (n = 1; n <= 4; n++) begin
      check_value({pulse_name(n), " pulses"}, expected_pulses[n], seen_pulses[n]);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
ccu_pkg.sv
ccu_register_file.sv
ccu_iteration_planner.sv
ccu_sequencer.sv
ccu_top.sv
tb_ccu.sv
